//--- verilog/dds_pkg.sv
/*
  Shared types and constants for the two-tone DDS channel.
  Holds the phase, scale and sample word types, the quarter-wave table
  size and the pipeline latencies that the RTL and the testbench rely on.
*/

package dds_pkg;

  // ******************************
  // word types
  // ******************************

  // phase word, a full turn is 2^16
  typedef logic [15:0] dds_phase_t;

  // unsigned amplitude, 0xffff is close to full scale
  typedef logic [15:0] dds_scale_t;

  // signed output sample
  typedef logic signed [15:0] dds_sample_t;

  // per-tone controls, 48 bits
  typedef struct packed {
    dds_phase_t incr;
    dds_phase_t init;
    dds_scale_t scale;
  } dds_tone_ctrl_t;

  // ******************************
  // table and pipeline constants
  // ******************************

  // index bits into the quarter-wave table
  localparam int DDS_LUT_ADDR_W = 6;

  // number of table entries
  localparam int DDS_LUT_DEPTH = 64;

  // angle to scaled sine inside the sine unit
  localparam int DDS_SINE_LATENCY = 3;

  // sync strobe at the top ports to first dependent sample
  // 1 accumulator + 3 sine + 1 sum + 1 output register
  localparam int DDS_PATH_LATENCY = 6;

endpackage

//--- verilog/dds_phase_accum.sv
/*
  Phase accumulator for one tone.
  Loads the initial phase on the sync strobe, otherwise advances by the
  programmed increment every clock, wrapping modulo 2^16.
*/

`timescale 1ns/1ps

module dds_phase_accum (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    sync,
  input  dds_pkg::dds_tone_ctrl_t ctrl,
  output dds_pkg::dds_phase_t     phase
);

  import dds_pkg::*;

  // phase register
  dds_phase_t phase_q;

  // next phase, natural 16-bit wrap
  dds_phase_t phase_next;

  // reload has priority over the increment
  always_comb begin
    if (sync) begin
      phase_next = ctrl.init;
    end else begin
      phase_next = phase_q + ctrl.incr;
    end
  end

  // the scale field is not used here, it goes to the combiner
  always_ff @(posedge clk) begin
    if (reset) begin
      phase_q <= '0;
    end else begin
      phase_q <= phase_next;
    end
  end

  assign phase = phase_q;

endmodule

//--- verilog/dds_sine_scale.sv
/*
  Quarter-wave sine lookup followed by amplitude scaling.
  The top two angle bits pick the quadrant and the next six index a 64-entry
  table. Three register stages give the scaled sine DDS_SINE_LATENCY
  cycles after its angle. The scale is expected one cycle after the angle.
*/

`timescale 1ns/1ps

module dds_sine_scale (
  input  logic                 clk,
  input  logic                 reset,
  input  dds_pkg::dds_phase_t  angle,
  input  dds_pkg::dds_scale_t  scale,
  output dds_pkg::dds_sample_t sine
);

  import dds_pkg::*;

  // quadrant and raw index from the angle
  logic [1:0]                quad;
  logic [DDS_LUT_ADDR_W-1:0] raw_index;

  // stage 1
  logic [DDS_LUT_ADDR_W-1:0] index_q;
  logic                      neg_q;

  // positive quarter-wave table output
  logic [14:0] lut_value;

  // stage 2
  dds_sample_t value_q;
  dds_scale_t  scale_q;

  // signed times unsigned needs 33 bits
  logic signed [32:0] product;
  dds_sample_t        product_sh;

  // stage 3
  dds_sample_t sine_q;

  assign quad      = angle[15:14];
  assign raw_index = angle[13:8];

  // ******************************
  // stage 1 quadrant folding
  // ******************************

  // odd quadrants run the table backwards and the lower half is negative
  always_ff @(posedge clk) begin
    if (reset) begin
      index_q <= '0;
      neg_q   <= 1'b0;
    end else begin
      index_q <= quad[0] ? ~raw_index : raw_index;
      neg_q   <= quad[1];
    end
  end

  // ******************************
  // stage 2 table lookup and sign
  // ******************************

  // entry k = round(32767 * sin(pi/2 * (k + 0.5) / 64))
  always_comb begin
    case (index_q)
      6'd0:  lut_value = 15'd402;
      6'd1:  lut_value = 15'd1206;
      6'd2:  lut_value = 15'd2009;
      6'd3:  lut_value = 15'd2811;
      6'd4:  lut_value = 15'd3612;
      6'd5:  lut_value = 15'd4410;
      6'd6:  lut_value = 15'd5205;
      6'd7:  lut_value = 15'd5998;
      6'd8:  lut_value = 15'd6786;
      6'd9:  lut_value = 15'd7571;
      6'd10: lut_value = 15'd8351;
      6'd11: lut_value = 15'd9126;
      6'd12: lut_value = 15'd9896;
      6'd13: lut_value = 15'd10659;
      6'd14: lut_value = 15'd11417;
      6'd15: lut_value = 15'd12167;
      6'd16: lut_value = 15'd12910;
      6'd17: lut_value = 15'd13645;
      6'd18: lut_value = 15'd14372;
      6'd19: lut_value = 15'd15090;
      6'd20: lut_value = 15'd15800;
      6'd21: lut_value = 15'd16499;
      6'd22: lut_value = 15'd17189;
      6'd23: lut_value = 15'd17869;
      6'd24: lut_value = 15'd18537;
      6'd25: lut_value = 15'd19195;
      6'd26: lut_value = 15'd19841;
      6'd27: lut_value = 15'd20475;
      6'd28: lut_value = 15'd21096;
      6'd29: lut_value = 15'd21705;
      6'd30: lut_value = 15'd22301;
      6'd31: lut_value = 15'd22884;
      6'd32: lut_value = 15'd23452;
      6'd33: lut_value = 15'd24007;
      6'd34: lut_value = 15'd24547;
      6'd35: lut_value = 15'd25072;
      6'd36: lut_value = 15'd25582;
      6'd37: lut_value = 15'd26077;
      6'd38: lut_value = 15'd26556;
      6'd39: lut_value = 15'd27019;
      6'd40: lut_value = 15'd27466;
      6'd41: lut_value = 15'd27896;
      6'd42: lut_value = 15'd28310;
      6'd43: lut_value = 15'd28706;
      6'd44: lut_value = 15'd29085;
      6'd45: lut_value = 15'd29447;
      6'd46: lut_value = 15'd29791;
      6'd47: lut_value = 15'd30117;
      6'd48: lut_value = 15'd30424;
      6'd49: lut_value = 15'd30714;
      6'd50: lut_value = 15'd30985;
      6'd51: lut_value = 15'd31237;
      6'd52: lut_value = 15'd31470;
      6'd53: lut_value = 15'd31685;
      6'd54: lut_value = 15'd31880;
      6'd55: lut_value = 15'd32057;
      6'd56: lut_value = 15'd32213;
      6'd57: lut_value = 15'd32351;
      6'd58: lut_value = 15'd32469;
      6'd59: lut_value = 15'd32567;
      6'd60: lut_value = 15'd32646;
      6'd61: lut_value = 15'd32705;
      6'd62: lut_value = 15'd32745;
      default: lut_value = 15'd32765;
    endcase
  end

  // scale arrives one cycle after the angle, so it meets its sample here
  always_ff @(posedge clk) begin
    if (reset) begin
      value_q <= '0;
      scale_q <= '0;
    end else begin
      value_q <= neg_q ? -$signed({1'b0, lut_value}) : $signed({1'b0, lut_value});
      scale_q <= scale;
    end
  end

  // ******************************
  // stage 3 amplitude scaling
  // ******************************

  // zero-extend the scale so the multiply stays signed
  assign product    = value_q * $signed({1'b0, scale_q});
  // magnitude stays below 2^31 so bits 31:16 hold the shifted result
  assign product_sh = product[31:16];

  always_ff @(posedge clk) begin
    if (reset) begin
      sine_q <= '0;
    end else begin
      sine_q <= product_sh;
    end
  end

  assign sine = sine_q;

endmodule

//--- verilog/dds_tone_combine.sv
/*
  Two-tone combiner.
  Runs two sine units, adds the scaled tones and registers the sum, then
  converts to offset binary on request in the output register. Phase to
  output takes 5 cycles. DISABLE = 1 ties the output to zero.
*/

`timescale 1ns/1ps

module dds_tone_combine #(
  parameter int DISABLE = 0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 dds_format,
  input  dds_pkg::dds_phase_t  phase_0,
  input  dds_pkg::dds_phase_t  phase_1,
  input  dds_pkg::dds_scale_t  scale_0,
  input  dds_pkg::dds_scale_t  scale_1,
  output dds_pkg::dds_sample_t dds_data
);

  import dds_pkg::*;

  // scales lined up with the angle register inside the sine units
  dds_scale_t scale_0_d;
  dds_scale_t scale_1_d;

  // scaled tones
  dds_sample_t sine_0;
  dds_sample_t sine_1;

  // sum and output registers
  dds_sample_t sum_q;
  dds_sample_t data_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      scale_0_d <= '0;
      scale_1_d <= '0;
    end else begin
      scale_0_d <= scale_0;
      scale_1_d <= scale_1;
    end
  end

  // ******************************
  // tone 0 and tone 1
  // ******************************

  dds_sine_scale u_sine_0 (
    .clk   (clk),
    .reset (reset),
    .angle (phase_0),
    .scale (scale_0_d),
    .sine  (sine_0)
  );

  dds_sine_scale u_sine_1 (
    .clk   (clk),
    .reset (reset),
    .angle (phase_1),
    .scale (scale_1_d),
    .sine  (sine_1)
  );

  // sum, then format conversion by flipping the sign bit
  always_ff @(posedge clk) begin
    if (reset) begin
      sum_q  <= '0;
      data_q <= '0;
    end else begin
      sum_q  <= sine_0 + sine_1;
      data_q <= {sum_q[15] ^ dds_format, sum_q[14:0]};
    end
  end

  // build-time option, a disabled channel outputs zero
  assign dds_data = (DISABLE == 1) ? '0 : data_q;

endmodule

//--- verilog/dds_tone_gen.sv
/*
  Top level of the two-tone DDS channel.
  Two phase accumulators feed the tone combiner. A sync strobe reloads both
  phases; the first sample built from the new phases appears
  DDS_PATH_LATENCY cycles later.
*/

`timescale 1ns/1ps

module dds_tone_gen (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    sync,
  input  logic                    dds_format,
  input  dds_pkg::dds_tone_ctrl_t tone_0,
  input  dds_pkg::dds_tone_ctrl_t tone_1,
  output dds_pkg::dds_sample_t    dds_data
);

  import dds_pkg::*;

  // running phases of both tones
  dds_phase_t phase_0;
  dds_phase_t phase_1;

  // ******************************
  // accumulators
  // ******************************

  dds_phase_accum u_accum_0 (
    .clk   (clk),
    .reset (reset),
    .sync  (sync),
    .ctrl  (tone_0),
    .phase (phase_0)
  );

  dds_phase_accum u_accum_1 (
    .clk   (clk),
    .reset (reset),
    .sync  (sync),
    .ctrl  (tone_1),
    .phase (phase_1)
  );

  // ******************************
  // combiner
  // ******************************

  // scales go straight in, the combiner aligns them to the phases
  dds_tone_combine #(
    .DISABLE (0)
  ) u_combine (
    .clk        (clk),
    .reset      (reset),
    .dds_format (dds_format),
    .phase_0    (phase_0),
    .phase_1    (phase_1),
    .scale_0    (tone_0.scale),
    .scale_1    (tone_1.scale),
    .dds_data   (dds_data)
  );

endmodule

//--- testbench/dds_tone_gen_tb.sv
/*
  Testbench for the two-tone DDS channel.
  Reads per-cycle stimulus and expected samples from the patterns file,
  drives dds_tone_gen and checks dds_data DDS_PATH_LATENCY cycles later.
*/

`timescale 1ns/1ps

module dds_tone_gen_tb;

  import dds_pkg::*;

  localparam int    RESET_CYCLES   = 10;
  localparam int    PATTERN_LINES  = 44;
  localparam int    TIMEOUT_CYCLES = 2 * PATTERN_LINES + RESET_CYCLES + 20;
  localparam int    MAX_TESTS      = 8;
  localparam string PATTERN_FILE   = "testbench/dds_tone_gen_patterns.txt";

  // one line of the patterns file
  typedef struct packed {
    logic [7:0]     test_id;
    logic           sync;
    logic           dds_format;
    dds_tone_ctrl_t tone_0;
    dds_tone_ctrl_t tone_1;
    dds_sample_t    expected;
  } pattern_t;

  logic           clk;
  logic           reset;
  logic           sync;
  logic           dds_format;
  dds_tone_ctrl_t tone_0;
  dds_tone_ctrl_t tone_1;
  dds_sample_t    dds_data;

  pattern_t    patterns[$];
  dds_sample_t exp_queue[$];
  int          test_queue[$];

  bit load_ok;
  int cycle_count;
  int check_count;
  int error_count;
  int cur_test;
  int test_checks[MAX_TESTS];
  int test_errors[MAX_TESTS];

  dds_tone_gen u_dds_tone_gen (
    .clk        (clk),
    .reset      (reset),
    .sync       (sync),
    .dds_format (dds_format),
    .tone_0     (tone_0),
    .tone_1     (tone_1),
    .dds_data   (dds_data)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run stopped by timeout after %0d cycles", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  // ******************************
  // helpers
  // ******************************

  task automatic compare_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected, input int test_id);
    check_count++;
    test_checks[test_id]++;
    if (actual !== expected) begin
      error_count++;
      test_errors[test_id]++;
      $display("Mismatch %s: got 0x%04h, expected 0x%04h in test %0d",
               name, actual, expected, test_id);
    end
  endtask

  // prints the finished test when the checked lines move to a new one
  task automatic note_test(input int test_id);
    if (test_id != cur_test) begin
      if (cur_test != 0) begin
        $display("test %0d done: %0d checks, %0d errors",
                 cur_test, test_checks[cur_test], test_errors[cur_test]);
      end
      cur_test = test_id;
    end
  endtask

  task automatic load_patterns();
    int       fd;
    int       fields;
    int       line_no;
    string    text;
    int       t_id, s_v, f_v, incr0, init0, scale0, incr1, init1, scale1, exp_v;
    pattern_t pat;
    load_ok = 1'b1;
    line_no = 0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("could not open the patterns file %s", PATTERN_FILE);
      load_ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        text = "";
        void'($fgets(text, fd));
        line_no++;
        // comment lines start with #, blank lines give no fields
        if (text.len() > 0 && text.getc(0) != "#") begin
          fields = $sscanf(text, "%d %h %h %h %h %h %h %h %h %h", t_id, s_v, f_v,
                           incr0, init0, scale0, incr1, init1, scale1, exp_v);
          if (fields == 10) begin
            pat.test_id      = t_id;
            pat.sync         = s_v;
            pat.dds_format   = f_v;
            pat.tone_0.incr  = incr0;
            pat.tone_0.init  = init0;
            pat.tone_0.scale = scale0;
            pat.tone_1.incr  = incr1;
            pat.tone_1.init  = init1;
            pat.tone_1.scale = scale1;
            pat.expected     = exp_v;
            patterns.push_back(pat);
          end else if (fields > 0) begin
            $display("line %0d of the patterns file is short, %0d of 10 fields",
                     line_no, fields);
            load_ok = 1'b0;
          end
        end
      end
      $fclose(fd);
      if (patterns.size() != PATTERN_LINES) begin
        $display("patterns file holds %0d lines, %0d were expected",
                 patterns.size(), PATTERN_LINES);
        load_ok = 1'b0;
      end
    end
  endtask

  // one line per cycle, each sample checked DDS_PATH_LATENCY cycles on
  task automatic run_patterns();
    int line;
    int test_id;
    dds_sample_t expected;
    for (line = 0; line < patterns.size() + DDS_PATH_LATENCY; line++) begin
      @(posedge clk);
      if (line < patterns.size()) begin
        sync       <= patterns[line].sync;
        dds_format <= patterns[line].dds_format;
        tone_0     <= patterns[line].tone_0;
        tone_1     <= patterns[line].tone_1;
        exp_queue.push_back(patterns[line].expected);
        test_queue.push_back(patterns[line].test_id);
      end
      // outputs settle well before the falling edge
      @(negedge clk);
      if (line >= DDS_PATH_LATENCY) begin
        expected = exp_queue.pop_front();
        test_id  = test_queue.pop_front();
        note_test(test_id);
        compare_value("dds_data", dds_data, expected, test_id);
      end
    end
  endtask

  // ******************************
  // main sequence
  // ******************************

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    sync        = 1'b0;
    dds_format  = 1'b0;
    tone_0      = '0;
    tone_1      = '0;
    cycle_count = 0;
    check_count = 0;
    error_count = 0;
    cur_test    = 0;
    load_patterns();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    // all registers cleared, output is zero in two's complement
    note_test(1);
    compare_value("dds_data", dds_data, 16'h0000, 1);
    if (load_ok) begin
      run_patterns();
    end
    note_test(0);
    $display("%0d checks, %0d errors", check_count, error_count);
    if (load_ok && error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/dds_tone_gen_patterns.txt
# test sync fmt incr0 init0 scale0 incr1 init1 scale1 expected, all but test in hex
# expected is dds_data 6 cycles after the line; it uses the scales of the next line
# and the format five lines below, so sync lines keep the old scales
1 0 0 0000 0000 0000 0000 0000 0000 0000
1 0 0 0000 0000 0000 0000 0000 0000 0000
1 0 0 0000 0000 0000 0000 0000 0000 0000
1 0 0 0000 0000 0000 0000 0000 0000 0000
2 1 0 1000 0000 0000 0000 0000 0000 0191
2 0 0 1000 0000 ffff 0000 0000 0000 326d
2 0 0 1000 0000 ffff 0000 0000 0000 5b9b
2 0 0 1000 0000 ffff 0000 0000 0000 76d7
2 0 0 1000 0000 ffff 0000 0000 0000 7ffc
2 0 0 1000 0000 ffff 0000 0000 0000 75a4
2 0 0 1000 0000 ffff 0000 0000 0000 5963
2 0 0 1000 0000 ffff 0000 0000 0000 2f86
2 0 0 1000 0000 ffff 0000 0000 0000 fe6e
2 0 0 1000 0000 ffff 0000 0000 0000 cd92
2 0 0 1000 0000 ffff 0000 0000 0000 a464
2 0 0 1000 0000 ffff 0000 0000 0000 8928
2 0 0 1000 0000 ffff 0000 0000 0000 8003
2 0 0 1000 0000 ffff 0000 0000 0000 8a5b
2 0 0 1000 0000 ffff 0000 0000 0000 a69c
2 0 0 1000 0000 ffff 0000 0000 0000 d079
2 0 0 1000 0000 ffff 0000 0000 0000 0191
2 0 0 1000 0000 ffff 0000 0000 0000 326d
3 1 0 1000 8000 ffff 0000 0000 0000 fe6e
3 0 0 1000 8000 ffff 0000 0000 0000 cd92
3 0 0 1000 8000 ffff 0000 0000 0000 a464
4 1 0 2000 0000 ffff 1000 4000 0000 20c8
4 0 0 2000 0000 8000 1000 4000 4000 4b37
4 0 0 2000 0000 8000 1000 4000 4000 5657
4 0 0 2000 0000 8000 1000 4000 4000 3893
4 0 0 2000 0000 8000 1000 4000 4000 fed2
4 0 0 2000 0000 8000 1000 4000 4000 c596
5 0 0 2000 0000 8000 1000 4000 4000 a91a
5 0 0 2000 0000 8000 1000 4000 4000 97e2
5 0 0 2000 0000 8000 1000 4000 8000 c0ca
5 0 0 2000 0000 8000 1000 4000 8000 f2fb
5 0 0 2000 0000 8000 1000 4000 8000 134c
6 0 0 2000 0000 8000 1000 4000 8000 94ee
6 0 0 2000 0000 8000 1000 4000 8000 8000
6 0 0 2000 0000 8000 1000 4000 8000 6b69
6 0 0 2000 0000 8000 1000 4000 8000 6dcf
6 0 0 2000 0000 8000 1000 4000 8000 8eba
6 0 1 2000 0000 8000 1000 4000 8000 c0c7
6 0 1 2000 0000 8000 1000 4000 8000 e8a0
6 0 1 2000 0000 8000 1000 4000 8000 ecb0

//--- dds_tone_gen.f
verilog/dds_pkg.sv
verilog/dds_phase_accum.sv
verilog/dds_sine_scale.sv
verilog/dds_tone_combine.sv
verilog/dds_tone_gen.sv
testbench/dds_tone_gen_tb.sv

//--- Bender.yml
package:
  name: dds_tone_gen

sources:
  - verilog/dds_pkg.sv
  - verilog/dds_phase_accum.sv
  - verilog/dds_sine_scale.sv
  - verilog/dds_tone_combine.sv
  - verilog/dds_tone_gen.sv
  - target: test
    files:
      - testbench/dds_tone_gen_tb.sv
